// File: Makefile
# Verilator build, run, lint and clean for the multiply unit

VERILATOR  ?= verilator
TOP        ?= tb_fp_mul_unit
FILELIST   ?= fp_mul_unit.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: fp_classify.sv
// --------------------------------------------------
// operand decoder: zero, nan, infinity, denormal
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_classify
  import fp_fmt_pkg::*;
(
  input  fp_word_t  operand_i,
  output fp_class_t class_o
);

  fp_fields_t fld;
  logic       exp_ones;
  logic       exp_zero;
  logic       man_zero;

  assign fld = operand_i.fields;

  assign exp_ones = (fld.exp == EXP_ONES);
  assign exp_zero = ~|fld.exp;
  assign man_zero = ~|fld.man;

  always_comb begin
    class_o.sign     = fld.sign;
    class_o.infty    = exp_ones & man_zero;
    class_o.nan      = exp_ones & ~man_zero;
    // quiet bit clear means signalling
    class_o.sig_nan  = exp_ones & ~man_zero & ~fld.man[MAN_W-1];
    class_o.zero     = exp_zero & man_zero;
    class_o.denormal = exp_zero & ~man_zero;
  end

endmodule

`default_nettype wire

// File: fp_flag_accum.sv
// --------------------------------------------------
// sticky exception flags of all taken results
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_flag_accum
  import fp_result_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      take_i,
  input  fp_flags_t flags_i,
  input  logic      clear_i,
  output fp_flags_t sticky_o
);

  fp_flags_t sticky_r;
  fp_flags_t kept;
  fp_flags_t added;

  assign kept  = clear_i ? '0 : sticky_r;   // clear drops only old bits
  assign added = take_i ? flags_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sticky_r <= '0;
    end else begin
      sticky_r <= kept | added;
    end
  end

  assign sticky_o = sticky_r;

endmodule

`default_nettype wire

// File: fp_fmt_pkg.sv
// --------------------------------------------------
// single-precision format constants and word types
// shared by the classifiers and the multiply pipeline
// --------------------------------------------------
`default_nettype none

package fp_fmt_pkg;

  localparam int EXP_W     = 8;
  localparam int MAN_W     = 23;
  localparam int WORD_W    = 32;
  localparam int EXP_BIAS  = 127;
  localparam int EXP_MAX   = 255;              // all ones exponent
  localparam int SIG_W     = MAN_W + 1;        // mantissa with hidden one
  localparam int PROD_W    = 2 * SIG_W;
  localparam int EXP_INT_W = EXP_W + 2;        // signed working exponent

  localparam logic [EXP_W-1:0] EXP_ONES = EXP_W'(EXP_MAX);
  localparam logic [MAN_W-1:0] QNAN_MAN = {1'b1, {(MAN_W-1){1'b0}}};
  localparam logic [MAN_W-1:0] SNAN_MAN = {1'b0, {(MAN_W-1){1'b1}}};

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp_fields_t;

  // one float word, seen raw on ports or split into fields
  typedef union packed {
    logic [WORD_W-1:0] raw;
    fp_fields_t        fields;
  } fp_word_t;

  // operand class as decoded from the fields
  typedef struct packed {
    logic zero;
    logic nan;       // any nan
    logic sig_nan;
    logic infty;
    logic denormal;
    logic sign;
  } fp_class_t;

endpackage

`default_nettype wire

// File: fp_mul_pipe.sv
// --------------------------------------------------
// three-stage single-precision multiplier with
// round to nearest-even and special-case results
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_mul_pipe
  import fp_fmt_pkg::*;
  import fp_result_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  fp_word_t   a_i,
  input  fp_word_t   b_i,
  input  fp_class_t  a_class_i,
  input  fp_class_t  b_class_i,
  input  logic       buf_full_i,
  input  logic       yumi_i,
  output logic       ready_o,
  output logic       v_o,
  output fp_result_t res_o
);

  logic stall;
  logic v_1_r, v_2_r, v_3_r;

  // whole pipe holds while the last result has nowhere to go
  assign stall   = v_3_r & buf_full_i & ~yumi_i;
  assign ready_o = ~stall;
  assign v_o     = v_3_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_1_r <= 1'b0;
      v_2_r <= 1'b0;
      v_3_r <= 1'b0;
    end else if (~stall) begin
      v_1_r <= valid_i;
      v_2_r <= v_1_r;
      v_3_r <= v_2_r;
    end
  end

  logic                        sign_in;
  logic signed [EXP_INT_W-1:0] exp_in;
  logic [SIG_W-1:0]            sig_a, sig_b;

  assign sign_in = a_class_i.sign ^ b_class_i.sign;
  assign exp_in  = EXP_INT_W'(a_i.fields.exp) + EXP_INT_W'(b_i.fields.exp)
                   - EXP_INT_W'(EXP_BIAS);  // biased sum, one bias removed
  assign sig_a   = {1'b1, a_i.fields.man};   // hidden one
  assign sig_b   = {1'b1, b_i.fields.man};

  // stage 1
  logic                        sign_1_r;
  logic signed [EXP_INT_W-1:0] exp_1_r;
  fp_class_t                   a_class_1_r, b_class_1_r;
  logic [SIG_W-1:0]            sig_a_1_r, sig_b_1_r;

  always_ff @(posedge clk_i) begin
    if (valid_i & ~stall) begin
      sign_1_r    <= sign_in;
      exp_1_r     <= exp_in;
      a_class_1_r <= a_class_i;
      b_class_1_r <= b_class_i;
      sig_a_1_r   <= sig_a;
      sig_b_1_r   <= sig_b;
    end
  end

  // stage 2
  logic                        sign_2_r;
  logic signed [EXP_INT_W-1:0] exp_2_r;
  fp_class_t                   a_class_2_r, b_class_2_r;
  logic [PROD_W-1:0]           prod_2_r;

  always_ff @(posedge clk_i) begin
    if (v_1_r & ~stall) begin
      sign_2_r    <= sign_1_r;
      exp_2_r     <= exp_1_r;
      a_class_2_r <= a_class_1_r;
      b_class_2_r <= b_class_1_r;
      prod_2_r    <= PROD_W'(sig_a_1_r) * PROD_W'(sig_b_1_r);
    end
  end

  logic                        prod_top;
  logic [MAN_W-1:0]            man_norm;
  logic                        guard_b, round_b, sticky_b;
  logic                        round_up;
  logic signed [EXP_INT_W-1:0] exp_norm;

  // product is in [1,4), top bit set means shift right by one
  assign prod_top = prod_2_r[PROD_W-1];

  always_comb begin
    if (prod_top) begin
      man_norm = prod_2_r[PROD_W-2 -: MAN_W];
      guard_b  = prod_2_r[MAN_W];
      round_b  = prod_2_r[MAN_W-1];
      sticky_b = |prod_2_r[MAN_W-2:0];
    end else begin
      man_norm = prod_2_r[PROD_W-3 -: MAN_W];
      guard_b  = prod_2_r[MAN_W-1];
      round_b  = prod_2_r[MAN_W-2];
      sticky_b = |prod_2_r[MAN_W-3:0];
    end
  end

  assign round_up = guard_b & (round_b | sticky_b | man_norm[0]);  // ties to even
  assign exp_norm = exp_2_r + EXP_INT_W'(prod_top);

  // stage 3
  logic                        sign_3_r;
  logic signed [EXP_INT_W-1:0] exp_3_r;
  fp_class_t                   a_class_3_r, b_class_3_r;
  logic [MAN_W-1:0]            man_3_r;
  logic                        round_up_3_r;

  always_ff @(posedge clk_i) begin
    if (v_2_r & ~stall) begin
      sign_3_r     <= sign_2_r;
      exp_3_r      <= exp_norm;
      a_class_3_r  <= a_class_2_r;
      b_class_3_r  <= b_class_2_r;
      man_3_r      <= man_norm;
      round_up_3_r <= round_up;
    end
  end

  logic                        rnd_carry;
  logic [MAN_W-1:0]            man_rnd;
  logic signed [EXP_INT_W-1:0] exp_fin;

  // a carry leaves the mantissa all zero, so only the exponent moves
  assign {rnd_carry, man_rnd} = {1'b0, man_3_r} + SIG_W'(round_up_3_r);
  assign exp_fin = exp_3_r + EXP_INT_W'(rnd_carry);

  always_comb begin
    res_o.flags             = '0;
    res_o.word.fields.sign  = sign_3_r;
    res_o.word.fields.exp   = EXP_ONES;   // quiet nan unless overridden
    res_o.word.fields.man   = QNAN_MAN;
    if (a_class_3_r.sig_nan | b_class_3_r.sig_nan) begin
      res_o.word.fields.man = SNAN_MAN;
      res_o.flags.invalid   = 1'b1;
    end else if (a_class_3_r.nan | b_class_3_r.nan) begin
      res_o.flags           = '0;
    end else if ((a_class_3_r.infty & b_class_3_r.zero) |
                 (b_class_3_r.infty & a_class_3_r.zero)) begin
      res_o.flags.invalid   = 1'b1;
    end else if (a_class_3_r.infty | b_class_3_r.infty) begin
      res_o.word.fields.man = '0;
    end else if (a_class_3_r.zero | b_class_3_r.zero) begin
      res_o.word.fields.exp = '0;
      res_o.word.fields.man = '0;
    end else if (a_class_3_r.denormal & b_class_3_r.denormal) begin
      res_o.word.fields.exp = '0;
      res_o.word.fields.man = '0;
      res_o.flags.underflow = 1'b1;
    end else if (a_class_3_r.denormal | b_class_3_r.denormal) begin
      res_o.flags.unimplemented = 1'b1;
    end else if (exp_fin <= 0) begin
      res_o.word.fields.exp = '0;   // flush to zero
      res_o.word.fields.man = '0;
      res_o.flags.underflow = 1'b1;
    end else if (exp_fin >= EXP_MAX) begin
      res_o.word.fields.man = '0;
      res_o.flags.overflow  = 1'b1;
    end else begin
      res_o.word.fields.exp = exp_fin[EXP_W-1:0];
      res_o.word.fields.man = man_rnd;
    end
  end

endmodule

`default_nettype wire

// File: fp_mul_unit.f
fp_fmt_pkg.sv
fp_result_pkg.sv
fp_classify.sv
fp_mul_pipe.sv
fp_result_fifo.sv
fp_flag_accum.sv
fp_mul_unit.sv
fp_mul_unit_asserts.sv
tb_fp_mul_unit.sv

// File: fp_mul_unit.sv
// --------------------------------------------------
// floating-point multiply unit: classifiers, pipe,
// result buffer and sticky flags
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unit
  import fp_fmt_pkg::*;
  import fp_result_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  fp_word_t   a_i,
  input  fp_word_t   b_i,
  input  logic       yumi_i,
  input  logic       clear_flags_i,
  output logic       ready_o,
  output logic       res_valid_o,
  output fp_result_t res_o,
  output fp_flags_t  sticky_flags_o
);

  fp_class_t  a_class, b_class;
  logic       pipe_v;
  fp_result_t pipe_res;
  logic       buf_full;
  logic       take;

  assign take = res_valid_o & yumi_i;

  fp_classify u_classify_a (
    .operand_i (a_i),
    .class_o   (a_class)
  );

  fp_classify u_classify_b (
    .operand_i (b_i),
    .class_o   (b_class)
  );

  fp_mul_pipe u_mul_pipe (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (valid_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .a_class_i  (a_class),
    .b_class_i  (b_class),
    .buf_full_i (buf_full),
    .yumi_i     (yumi_i),
    .ready_o    (ready_o),
    .v_o        (pipe_v),
    .res_o      (pipe_res)
  );

  fp_result_fifo u_result_fifo (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_v_i    (pipe_v),
    .wr_data_i (pipe_res),
    .yumi_i    (yumi_i),
    .full_o    (buf_full),
    .v_o       (res_valid_o),
    .data_o    (res_o)
  );

  fp_flag_accum u_flag_accum (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .take_i   (take),
    .flags_i  (res_o.flags),
    .clear_i  (clear_flags_i),
    .sticky_o (sticky_flags_o)
  );

endmodule

`default_nettype wire

// File: fp_mul_unit_asserts.sv
// --------------------------------------------------
// protocol checks on the result buffer and outputs
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unit_asserts
  import fp_result_pkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input logic       ready_i,
  input logic       res_valid_i,
  input fp_result_t res_i,
  input logic       yumi_i,
  input logic       last_v_i,     // pipeline stage 3 valid
  input logic       buf_full_i
);

  // head entry holds until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_i && !yumi_i) |=> (res_valid_i && $stable(res_i)))
    else $error("result output changed before it was taken");

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> res_valid_i)
    else $error("yumi raised with no valid result");

  assert property (@(posedge clk_i) disable iff (reset_i)
    !ready_i |-> (last_v_i && buf_full_i))
    else $error("ready dropped without a full buffer and a waiting result");

endmodule

bind fp_mul_unit fp_mul_unit_asserts u_asserts (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .ready_i     (ready_o),
  .res_valid_i (res_valid_o),
  .res_i       (res_o),
  .yumi_i      (yumi_i),
  .last_v_i    (pipe_v),
  .buf_full_i  (buf_full)
);

`default_nettype wire

// File: fp_result_fifo.sv
// --------------------------------------------------
// four-entry result buffer, drained by yumi
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_result_fifo
  import fp_result_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       wr_v_i,
  input  fp_result_t wr_data_i,
  input  logic       yumi_i,
  output logic       full_o,
  output logic       v_o,
  output fp_result_t data_o
);

  fp_result_t           mem [RES_DEPTH];
  logic [RES_PTR_W-1:0] wr_ptr_r, rd_ptr_r;
  logic [RES_CNT_W-1:0] count_r;
  logic                 enq, deq;

  assign full_o = (count_r == RES_CNT_W'(RES_DEPTH));
  assign v_o    = (count_r != '0);
  assign data_o = mem[rd_ptr_r];   // head visible right after the write

  assign deq = yumi_i & v_o;
  assign enq = wr_v_i & (~full_o | deq);  // full is fine if a slot frees now

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;   // depth is a power of two
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_r + RES_CNT_W'(enq) - RES_CNT_W'(deq);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem[wr_ptr_r] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: fp_result_pkg.sv
// --------------------------------------------------
// multiply result and exception flag types, plus
// the result buffer sizing
// --------------------------------------------------
`default_nettype none

package fp_result_pkg;

  import fp_fmt_pkg::*;

  localparam int RES_DEPTH = 4;
  localparam int RES_PTR_W = 2;
  localparam int RES_CNT_W = RES_PTR_W + 1;   // holds 0..RES_DEPTH

  // ieee-style exception flags
  typedef struct packed {
    logic unimplemented;   // denormal operand
    logic invalid;
    logic overflow;
    logic underflow;
  } fp_flags_t;

  // one buffer entry
  typedef struct packed {
    fp_word_t  word;
    fp_flags_t flags;
  } fp_result_t;

endpackage

`default_nettype wire

// File: tb_fp_mul_unit.sv
// --------------------------------------------------
// testbench for the floating-point multiply unit
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 20;   // 40 ns clock

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

module tb_fp_mul_unit
  import fp_fmt_pkg::*;
  import fp_result_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 16;
  localparam int ROW_CYCLES   = 200;
  localparam int N_VEC        = 21;
  localparam int G1_LAST      = 9;     // normals, overflow, underflow
  localparam int WATCHDOG_NS  = CLK_PERIOD * (RESET_CYCLES + ROW_CYCLES * N_VEC);

  typedef struct packed {
    fp_word_t   a;
    fp_word_t   b;
    fp_result_t res;
  } vec_t;

  logic       clk_i, reset_i, valid_i, yumi_i, clear_flags_i;
  logic       ready_o, res_valid_o;
  fp_word_t   a_i, b_i;
  fp_result_t res_o;
  fp_flags_t  sticky_flags_o;

  vec_t       vec_tab [N_VEC];
  fp_result_t exp_q [$];           // results still owed, in order
  fp_flags_t  model_flags = '0;
  logic       saw_stall   = 1'b0;
  integer     seed        = 32'he703_0809;

  tb_clock_gen u_clock_gen (.clk_o(clk_i));

  fp_mul_unit u_fp_mul_unit (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (valid_i),
    .a_i            (a_i),
    .b_i            (b_i),
    .yumi_i         (yumi_i),
    .clear_flags_i  (clear_flags_i),
    .ready_o        (ready_o),
    .res_valid_o    (res_valid_o),
    .res_o          (res_o),
    .sticky_flags_o (sticky_flags_o)
  );

  task automatic report_fail();
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic vec_t make_vec(input logic [31:0] a, input logic [31:0] b,
                                    input logic [31:0] w, input logic [3:0] f);
    vec_t v;
    v.a.raw       = a;
    v.b.raw       = b;
    v.res.word.raw = w;
    v.res.flags   = f;
    return v;
  endfunction

  // flags order: unimplemented, invalid, overflow, underflow
  task automatic load_table();
    vec_tab[0]  = make_vec(32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000, 4'b0000); // exact
    vec_tab[1]  = make_vec(32'hC000_0000, 32'h4040_0000, 32'hC0C0_0000, 4'b0000); // -6
    vec_tab[2]  = make_vec(32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000, 4'b0000); // into exp
    vec_tab[3]  = make_vec(32'h3F80_0001, 32'h3F80_0001, 32'h3F80_0002, 4'b0000); // round down
    vec_tab[4]  = make_vec(32'h3FC0_0001, 32'h3FC0_0000, 32'h4010_0001, 4'b0000); // round up
    vec_tab[5]  = make_vec(32'h3F80_0001, 32'h3FC0_0000, 32'h3FC0_0002, 4'b0000); // tie, up
    vec_tab[6]  = make_vec(32'h3FFF_0100, 32'h3F80_8000, 32'h4000_0000, 4'b0000); // tie, down
    vec_tab[7]  = make_vec(32'h3F84_2108, 32'h3FF8_0000, 32'h4000_0000, 4'b0000); // round carry
    vec_tab[8]  = make_vec(32'h7F00_0000, 32'h4000_0000, 32'h7F80_0000, 4'b0010);
    vec_tab[9]  = make_vec(32'h0080_0000, 32'h3F00_0000, 32'h0000_0000, 4'b0001);
    vec_tab[10] = make_vec(32'h7F80_0001, 32'h3F80_0000, 32'h7FBF_FFFF, 4'b0100); // snan
    vec_tab[11] = make_vec(32'h7FC0_0000, 32'hC000_0000, 32'hFFC0_0000, 4'b0000); // qnan
    vec_tab[12] = make_vec(32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000, 4'b0100); // inf * 0
    vec_tab[13] = make_vec(32'hFF80_0000, 32'h4000_0000, 32'hFF80_0000, 4'b0000);
    vec_tab[14] = make_vec(32'h8000_0000, 32'h4040_0000, 32'h8000_0000, 4'b0000);
    vec_tab[15] = make_vec(32'h0000_0001, 32'h8000_0010, 32'h8000_0000, 4'b0001); // two denorm
    vec_tab[16] = make_vec(32'h0040_0000, 32'h4000_0000, 32'h7FC0_0000, 4'b1000);
    vec_tab[17] = make_vec(32'h0000_0001, 32'h0000_0000, 32'h0000_0000, 4'b0000); // zero wins
    vec_tab[18] = make_vec(32'h8080_0000, 32'h3F00_0000, 32'h8000_0000, 4'b0001);
    vec_tab[19] = make_vec(32'hFF80_0001, 32'h7F80_0000, 32'hFFBF_FFFF, 4'b0100);
    vec_tab[20] = make_vec(32'h7FC0_0000, 32'h7F80_0001, 32'h7FBF_FFFF, 4'b0100);
  endtask

  function automatic fp_flags_t group_flags(input int lo, input int hi);
    fp_flags_t acc;
    acc = '0;
    for (int i = lo; i <= hi; i++) begin
      acc = acc | vec_tab[i].res.flags;
    end
    return acc;
  endfunction

  task automatic expect_sticky(input fp_flags_t want);
    assert (sticky_flags_o == want) else begin
      $display("mismatch sticky_flags_o: got %h expected %h", sticky_flags_o, want);
      report_fail();
    end
  endtask

  // holds each pair until the edge where ready_o is high
  task automatic send_rows(input int first, input int last);
    logic took;
    @(posedge clk_i);
    #DRIVE_DLY;
    for (int i = first; i <= last; i++) begin
      valid_i = 1'b1;
      a_i     = vec_tab[i].a;
      b_i     = vec_tab[i].b;
      exp_q.push_back(vec_tab[i].res);
      do begin
        @(negedge clk_i);
        took = ready_o;
        @(posedge clk_i);
        #DRIVE_DLY;
      end while (!took);
    end
    valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  initial begin : main
    reset_i       = 1'b1;
    valid_i       = 1'b0;
    a_i           = '0;
    b_i           = '0;
    clear_flags_i = 1'b0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;
    @(negedge clk_i);
    assert (!res_valid_o && ready_o) else begin
      $display("mismatch res_valid_o/ready_o after reset: got %h/%h expected 0/1",
               res_valid_o, ready_o);
      report_fail();
    end
    expect_sticky('0);

    send_rows(0, G1_LAST);
    wait_drain();
    expect_sticky(group_flags(0, G1_LAST));

    @(posedge clk_i);
    #DRIVE_DLY;
    clear_flags_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    clear_flags_i = 1'b0;
    @(negedge clk_i);
    expect_sticky('0);

    send_rows(G1_LAST + 1, N_VEC - 1);
    wait_drain();
    expect_sticky(group_flags(G1_LAST + 1, N_VEC - 1));
    assert (!res_valid_o) else begin
      $display("result buffer still holds an entry after all rows were taken");
      report_fail();
    end
    assert (saw_stall) else begin
      $display("ready_o never dropped while the consumer was slow");
      report_fail();
    end
    $display(">>> PASS");
    $finish;
  end

  // sparse yumi, checked against the queue on every take
  initial begin : consumer
    fp_result_t exp_res;
    int         rnd;
    yumi_i = 1'b0;
    wait (!reset_i);
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      rnd    = $random(seed);
      yumi_i = res_valid_o & (rnd[1:0] == 2'b00);
      @(negedge clk_i);
      expect_sticky(model_flags);
      if (!ready_o) saw_stall = 1'b1;
      if (clear_flags_i) model_flags = '0;
      if (yumi_i) begin
        assert (exp_q.size() != 0) else begin
          $display("a result appeared with no operand pair pending");
          report_fail();
        end
        exp_res = exp_q.pop_front();
        assert (res_o.word.raw == exp_res.word.raw) else begin
          $display("mismatch res_o.word: got %h expected %h", res_o.word.raw,
                   exp_res.word.raw);
          report_fail();
        end
        assert (res_o.flags == exp_res.flags) else begin
          $display("mismatch res_o.flags: got %h expected %h", res_o.flags, exp_res.flags);
          report_fail();
        end
        model_flags = model_flags | exp_res.flags;   // taken at the coming edge
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run hung with %0d results still owed", exp_q.size());
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
